// ==== sources.f ====
hdl/rv_pkg.sv
hdl/int_decode.sv
hdl/int_regfile.sv
hdl/exec_int.sv
hdl/int_writeback.sv
hdl/int_core_top.sv
verif/int_core_checker.sv
verif/tb_int_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the integer core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_int_core -f sources.f \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vtb_int_core +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "Simulator exited with a nonzero status"
cat sim.log

grep -qF '*** TEST PASSED ***' sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== verif/tb_int_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_int_core;
    import rv_pkg::*;

    logic        clk;
    logic        rst;
    logic        i_valid;
    instr_t      i_instr;
    addr_t       i_pc;
    logic        o_retire_valid;
    reg_idx_t    o_retire_rd;
    xlen_t       o_retire_data;
    logic        o_trap_valid;
    trap_cause_t o_trap_cause;
    addr_t       o_trap_pc;

    logic [31:0] lfsr = 32'h410f_1570;
    addr_t       pc = 64'hffff_fff0_0000_1000;
    xlen_t       model_regs [0:31];
    logic        p1_wr = 1'b0;  // Write issued last cycle, not yet visible
    reg_idx_t    p1_rd;
    xlen_t       p1_data;
    logic        p2_wr = 1'b0;  // Issued two cycles back, visible from now on
    reg_idx_t    p2_rd;
    xlen_t       p2_data;
    logic        exp_trap [$];
    reg_idx_t    exp_rd [$];
    xlen_t       exp_val [$];  // Result, or the address for a trap
    logic        cmp_trap;
    reg_idx_t    cmp_rd;
    xlen_t       cmp_val;
    int          mismatches = 0;
    int          other_errors = 0;
    int          checked = 0;

    int_core_top int_core_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic instr_t r_type(input opcode_t opc, input logic [2:0] f3,
                                      input logic [6:0] f7, input reg_idx_t rd,
                                      input reg_idx_t rs1, input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic instr_t i_type(input opcode_t opc, input logic [2:0] f3,
                                      input logic [11:0] imm, input reg_idx_t rd,
                                      input reg_idx_t rs1);
        return {imm, rs1, f3, rd, opc, 2'b11};
    endfunction

    // Expected outcome of one instruction from its encoding and source values
    function automatic void ref_exec(input instr_t ins, input addr_t ipc, input xlen_t a,
                                     input xlen_t b, output logic trap, output xlen_t res);
        opcode_t     opc;
        logic [2:0]  f3;
        logic        reg_op;  // Second operand from rs2
        xlen_t       op2;
        logic [4:0]  sh;
        logic [31:0] w;
        opc    = ins[6:2];
        f3     = ins[14:12];
        reg_op = ins[5];
        op2    = reg_op ? b : {{52{ins[31]}}, ins[31:20]};
        sh     = op2[4:0];
        trap   = 1'b0;
        res    = '0;
        w      = '0;
        if (ins[1:0] != 2'b11) begin
            trap = 1'b1;
        end else if (opc == OPC_LUI || opc == OPC_AUIPC) begin
            res = {{32{ins[31]}}, ins[31:12], 12'h000};
            res = (opc == OPC_AUIPC) ? res + ipc : res;
        end else if (opc == OPC_OP_IMM || opc == OPC_OP) begin
            case (f3)
                3'd0: res = (reg_op && ins[30]) ? a - op2 : a + op2;
                3'd1: res = a << op2[5:0];
                3'd2: res = {63'd0, $signed(a) < $signed(op2)};
                3'd3: res = {63'd0, a < op2};
                3'd4: res = a ^ op2;
                3'd5: res = ins[30] ? 64'({{64{a[63]}}, a} >> op2[5:0]) : a >> op2[5:0];
                3'd6: res = a | op2;
                default: res = a & op2;
            endcase
            trap = !reg_op && ((f3 == 3'd1 && ins[31:26] != 6'd0)
                   || (f3 == 3'd5 && (ins[31] || ins[29:26] != 4'd0)));
        end else if (opc == OPC_OP_IMM_32 || opc == OPC_OP_32) begin
            case (f3)
                3'd0: w = (reg_op && ins[30]) ? a[31:0] - op2[31:0] : a[31:0] + op2[31:0];
                3'd1: w = a[31:0] << sh;
                3'd5: w = ins[30] ? 32'({{32{a[31]}}, a[31:0]} >> sh) : a[31:0] >> sh;
                default: trap = 1'b1;
            endcase
            res  = {{32{w[31]}}, w};
            trap = trap || (!reg_op && ((f3 == 3'd1 && ins[31:25] != 7'd0)
                   || (f3 == 3'd5 && (ins[31] || ins[29:25] != 5'd0))));
        end else begin
            trap = 1'b1;
        end
    endfunction

    // Drives one cycle and moves the model forward by one cycle
    task automatic issue(input logic valid, input instr_t ins);
        logic  trap;
        xlen_t res;
        @(negedge clk);
        if (p2_wr) begin
            model_regs[p2_rd] = p2_data;
        end
        p2_wr   = p1_wr;
        p2_rd   = p1_rd;
        p2_data = p1_data;
        p1_wr   = 1'b0;
        i_valid = valid;
        i_instr = ins;
        i_pc    = pc;
        if (valid) begin
            ref_exec(ins, pc, model_regs[ins[19:15]], model_regs[ins[24:20]], trap, res);
            exp_trap.push_back(trap);
            exp_rd.push_back(ins[11:7]);
            exp_val.push_back(trap ? pc : res);
            p1_wr   = !trap && (ins[11:7] != 5'd0);  // x0 is never written
            p1_rd   = ins[11:7];
            p1_data = res;
            pc      = pc + 64'd4;
        end
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (!rst && (o_retire_valid || o_trap_valid)) begin
            if (exp_trap.size() == 0) begin
                other_errors++;
                $display("Output pulse at %0t ns with no instruction outstanding", $time);
            end else begin
                cmp_trap = exp_trap.pop_front();
                cmp_rd   = exp_rd.pop_front();
                cmp_val  = exp_val.pop_front();
                checked++;
                check_value("trap valid", 64'(o_trap_valid), 64'(cmp_trap));
                check_value("retire valid", 64'(o_retire_valid), 64'(!cmp_trap));
                if (cmp_trap) begin
                    check_value("trap cause", 64'(o_trap_cause), 64'd2);
                    check_value("trap pc", o_trap_pc, cmp_val);
                end else begin
                    check_value("retire rd", 64'(o_retire_rd), 64'(cmp_rd));
                    check_value("retire data", o_retire_data, cmp_val);
                end
            end
        end
    end

    initial begin
        opcode_t    opc;
        logic [6:0] f7;
        int         waited;
        rst     = 1'b1;
        i_valid = 1'b1;  // Offered during reset, must be dropped
        i_instr = i_type(OPC_OP_IMM, 3'd0, 12'h001, 5'd1, 5'd0);
        i_pc    = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst     = 1'b0;
        i_valid = 1'b0;

        // Operands: LUI everywhere, ADDI well past the LUI, then widen odd ones
        for (int r = 1; r < 32; r++) begin
            issue(1'b1, {20'(rand_bits(20)), 5'(r), OPC_LUI, 2'b11});
        end
        for (int r = 1; r < 32; r++) begin
            issue(1'b1, i_type(OPC_OP_IMM, 3'd0, 12'(rand_bits(12)), 5'(r), 5'(r)));
        end
        for (int r = 1; r < 32; r += 2) begin
            issue(1'b1, i_type(OPC_OP_IMM, 3'd1, {6'd0, 6'(rand_bits(6))}, 5'(r), 5'(r)));
        end

        // x5 read at distances 1, 2 and 3, then a write to x0 read back
        issue(1'b1, i_type(OPC_OP_IMM, 3'd0, 12'h123, 5'd5, 5'd0));
        issue(1'b1, r_type(OPC_OP, 3'd0, 7'd0, 5'd6, 5'd5, 5'd0));
        issue(1'b1, r_type(OPC_OP, 3'd0, 7'd0, 5'd7, 5'd5, 5'd0));
        issue(1'b1, r_type(OPC_OP, 3'd0, 7'd0, 5'd8, 5'd5, 5'd0));
        issue(1'b1, i_type(OPC_OP_IMM, 3'd0, 12'h7ff, 5'd0, 5'd1));
        issue(1'b0, '0);
        issue(1'b1, r_type(OPC_OP, 3'd0, 7'd0, 5'd9, 5'd0, 5'd0));

        // Traps must not touch x3, x4 or x10
        issue(1'b1, i_type(OPC_OP_IMM, 3'd1, 12'h405, 5'd3, 5'd3));     // SLLI, bit 30 set
        issue(1'b1, i_type(5'b00000, 3'd3, 12'h000, 5'd4, 5'd4));       // Load
        issue(1'b1, i_type(OPC_OP_IMM_32, 3'd5, 12'h021, 5'd10, 5'd10)); // SRLIW, bit 25 set
        issue(1'b0, '0);
        issue(1'b1, r_type(OPC_OP, 3'd0, 7'd0, 5'd11, 5'd3, 5'd4));
        issue(1'b1, r_type(OPC_OP, 3'd6, 7'd0, 5'd12, 5'd10, 5'd0));

        // Random mix over x0 to x15, so that close dependencies are common
        for (int n = 0; n < 600; n++) begin
            case (rand_bits(3))
                0, 1: opc = OPC_OP_IMM;
                2, 3: opc = OPC_OP;
                4: opc = OPC_OP_IMM_32;
                5: opc = OPC_OP_32;
                6: opc = rand_bits(1) ? OPC_LUI : OPC_AUIPC;
                default: opc = 5'(rand_bits(5));  // Mostly unsupported
            endcase
            f7 = {1'b0, 1'(rand_bits(1)), 4'd0, 1'(rand_bits(1))};
            if (rand_bits(3) == 0) begin
                f7 = 7'(rand_bits(7));  // Reserved bits, traps for shift immediates
            end
            issue(1'b1, {f7, 5'(rand_bits(4)), 5'(rand_bits(4)), 3'(rand_bits(3)),
                         5'(rand_bits(4)), opc, (rand_bits(4) == 0) ? 2'(rand_bits(2)) : 2'b11});
        end
        issue(1'b0, '0);

        waited = 0;
        while (exp_trap.size() != 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (exp_trap.size() != 0) begin
            other_errors++;
            $display("Timeout: %0d expected reports never arrived", exp_trap.size());
        end
        other_errors += int_core_top_inst.u_checker.fail_count;
        $display("Reports checked: %0d, mismatches: %0d, other errors: %0d",
                 checked, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/int_core_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_core_checker (
    input wire clk,
    input wire rst,
    input wire i_valid,
    input wire i_d_valid,
    input wire i_e_valid,
    input wire i_retire_valid,
    input wire i_trap_valid
);

    int fail_count = 0;  // Assertion failures seen so far

    // One report kind per instruction
    report_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(i_retire_valid && i_trap_valid))
    else begin
        $error("Retire and trap pulses overlap");
        fail_count++;
    end

    // Fixed three-stage latency, no lost and no extra reports
    report_latency: assert property (@(posedge clk) disable iff (rst)
        !$past(rst, 3) |-> (i_retire_valid || i_trap_valid) == $past(i_valid, 3))
    else begin
        $error("Report does not follow an accepted instruction by 3 cycles");
        fail_count++;
    end

    valids_clear: assert property (@(posedge clk)
        $fell(rst) |-> !(i_d_valid || i_e_valid || i_retire_valid || i_trap_valid))
    else begin
        $error("Valid high in the first cycle after reset");
        fail_count++;
    end

endmodule

bind int_core_top int_core_checker u_checker (
    .clk            (clk),
    .rst            (rst),
    .i_valid        (i_valid),
    .i_d_valid      (d_valid),
    .i_e_valid      (e_valid),
    .i_retire_valid (o_retire_valid),
    .i_trap_valid   (o_trap_valid)
);

`default_nettype wire

// ==== hdl/int_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_core_top (
    input  wire                     clk,
    input  wire                     rst,

    input  wire                     i_valid,
    input  wire  rv_pkg::instr_t    i_instr,
    input  wire  rv_pkg::addr_t     i_pc,

    output logic                    o_retire_valid,
    output rv_pkg::reg_idx_t        o_retire_rd,
    output rv_pkg::xlen_t           o_retire_data,
    output logic                    o_trap_valid,
    output rv_pkg::trap_cause_t     o_trap_cause,
    output rv_pkg::addr_t           o_trap_pc
);
    import rv_pkg::*;

    // Register file ports
    reg_idx_t    rs1_addr;
    reg_idx_t    rs2_addr;
    xlen_t       rf_rs1_data;
    xlen_t       rf_rs2_data;
    logic        wr_en;
    reg_idx_t    wr_addr;
    xlen_t       wr_data;

    // Decode stage
    logic        d_valid;
    addr_t       d_pc;
    opcode_t     d_opcode;
    logic [2:0]  d_funct3;
    reg_idx_t    d_rd;
    xlen_t       d_rs1_data;
    xlen_t       d_rs2_data;
    logic [31:20] d_i_imm;
    logic [31:12] d_u_imm;

    // Execute stage
    logic        e_valid;
    logic        e_exception;
    trap_cause_t e_trap_cause;
    xlen_t       e_result;
    reg_idx_t    e_rd;
    addr_t       e_pc;

    int_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (i_valid),
        .i_instr    (i_instr),
        .i_pc       (i_pc),
        .o_rs1_addr (rs1_addr),
        .o_rs2_addr (rs2_addr),
        .i_rs1_data (rf_rs1_data),
        .i_rs2_data (rf_rs2_data),
        .o_valid    (d_valid),
        .o_pc       (d_pc),
        .o_opcode   (d_opcode),
        .o_funct3   (d_funct3),
        .o_rd       (d_rd),
        .o_rs1_data (d_rs1_data),
        .o_rs2_data (d_rs2_data),
        .o_i_imm    (d_i_imm),
        .o_u_imm    (d_u_imm)
    );

    int_regfile u_regfile (
        .clk        (clk),
        .rst        (rst),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .o_rs1_data (rf_rs1_data),
        .o_rs2_data (rf_rs2_data),
        .i_wr_en    (wr_en),
        .i_wr_addr  (wr_addr),
        .i_wr_data  (wr_data)
    );

    exec_int u_exec (
        .clk          (clk),
        .rst          (rst),
        .i_valid      (d_valid),
        .i_pc         (d_pc),
        .i_opcode     (d_opcode),
        .i_funct3     (d_funct3),
        .i_rd         (d_rd),
        .i_rs1_data   (d_rs1_data),
        .i_rs2_data   (d_rs2_data),
        .i_i_imm      (d_i_imm),
        .i_u_imm      (d_u_imm),
        .o_valid      (e_valid),
        .o_exception  (e_exception),
        .o_trap_cause (e_trap_cause),
        .o_result     (e_result),
        .o_rd         (e_rd),
        .o_pc         (e_pc)
    );

    int_writeback u_writeback (
        .clk            (clk),
        .rst            (rst),
        .i_valid        (e_valid),
        .i_exception    (e_exception),
        .i_trap_cause   (e_trap_cause),
        .i_result       (e_result),
        .i_rd           (e_rd),
        .i_pc           (e_pc),
        .o_wr_en        (wr_en),
        .o_wr_addr      (wr_addr),
        .o_wr_data      (wr_data),
        .o_retire_valid (o_retire_valid),
        .o_retire_rd    (o_retire_rd),
        .o_retire_data  (o_retire_data),
        .o_trap_valid   (o_trap_valid),
        .o_trap_cause   (o_trap_cause),
        .o_trap_pc      (o_trap_pc)
    );

endmodule

`default_nettype wire

// ==== hdl/int_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_writeback (
    input  wire                        clk,
    input  wire                        rst,

    // From execute
    input  wire                        i_valid,
    input  wire                        i_exception,
    input  wire  rv_pkg::trap_cause_t  i_trap_cause,
    input  wire  rv_pkg::xlen_t        i_result,
    input  wire  rv_pkg::reg_idx_t     i_rd,
    input  wire  rv_pkg::addr_t        i_pc,

    // Register file write
    output logic                       o_wr_en,
    output rv_pkg::reg_idx_t           o_wr_addr,
    output rv_pkg::xlen_t              o_wr_data,

    // Reports
    output logic                       o_retire_valid,
    output rv_pkg::reg_idx_t           o_retire_rd,
    output rv_pkg::xlen_t              o_retire_data,
    output logic                       o_trap_valid,
    output rv_pkg::trap_cause_t        o_trap_cause,
    output rv_pkg::addr_t              o_trap_pc
);

    logic retire;

    assign retire = i_valid && !i_exception;

    // Write lands on the same edge that raises the retire pulse
    assign o_wr_en   = retire && (i_rd != '0);
    assign o_wr_addr = i_rd;
    assign o_wr_data = i_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_retire_valid <= 1'b0;
            o_trap_valid   <= 1'b0;
        end else begin
            o_retire_valid <= retire;
            o_trap_valid   <= i_valid && i_exception;
        end
    end

    always_ff @(posedge clk) begin
        o_retire_rd   <= i_rd;
        o_retire_data <= i_result;  // Reported for x0 too
        o_trap_cause  <= i_trap_cause;
        o_trap_pc     <= i_pc;
    end

endmodule

`default_nettype wire

// ==== hdl/exec_int.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_int (
    input  wire                     clk,
    input  wire                     rst,

    input  wire                     i_valid,
    input  wire  rv_pkg::addr_t     i_pc,
    input  wire  rv_pkg::opcode_t   i_opcode,
    input  wire  [2:0]              i_funct3,
    input  wire  rv_pkg::reg_idx_t  i_rd,
    input  wire  rv_pkg::xlen_t     i_rs1_data,
    input  wire  rv_pkg::xlen_t     i_rs2_data,
    input  wire  [31:20]            i_i_imm,
    input  wire  [31:12]            i_u_imm,

    output logic                    o_valid,
    output logic                    o_exception,
    output rv_pkg::trap_cause_t     o_trap_cause,
    output rv_pkg::xlen_t           o_result,
    output rv_pkg::reg_idx_t        o_rd,
    output rv_pkg::addr_t           o_pc
);
    import rv_pkg::*;

    xlen_t      imm_i_ext;  // Sign-extended I-immediate
    xlen_t      imm_u_ext;  // Sign-extended U-immediate, low 12 bits zero
    logic [5:0] shamt_i;
    logic [5:0] shamt_r;
    logic       alt;        // Bit 30 picks SUB and SRA variants

    assign imm_i_ext = {{(XLEN-12){i_i_imm[31]}}, i_i_imm};
    assign imm_u_ext = {{(XLEN-32){i_u_imm[31]}}, i_u_imm, 12'b0};
    assign shamt_i   = i_i_imm[25:20];
    assign shamt_r   = i_rs2_data[5:0];
    assign alt       = i_i_imm[30];

    // W results are sign-extended from bit 31
    function automatic xlen_t sext32(input logic [31:0] val);
        return {{(XLEN-32){val[31]}}, val};
    endfunction

    function automatic xlen_t shr64(input xlen_t val, input logic [5:0] sh, input logic arith);
        if (arith) begin
            return xlen_t'($signed(val) >>> sh);
        end else begin
            return val >> sh;
        end
    endfunction

    function automatic logic [31:0] shr32(input logic [31:0] val, input logic [4:0] sh,
                                          input logic arith);
        if (arith) begin
            return 32'($signed(val) >>> sh);
        end else begin
            return val >> sh;
        end
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        o_rd         <= i_rd;
        o_pc         <= i_pc;
        o_exception  <= 1'b0;
        o_trap_cause <= EXC_ILLEGAL_INSTR;  // Only cause raised by this unit
        o_result     <= '0;

        case (i_opcode)
            OPC_LUI: begin
                o_result <= imm_u_ext;
            end
            OPC_AUIPC: begin
                o_result <= i_pc + imm_u_ext;
            end
            OPC_OP_IMM: begin
                unique case (i_funct3)
                    3'b000: o_result <= i_rs1_data + imm_i_ext;  // ADDI
                    3'b001: begin  // SLLI
                        o_exception <= i_i_imm[31:26] != '0;
                        o_result    <= i_rs1_data << shamt_i;
                    end
                    3'b010: begin  // SLTI
                        o_result <= {{(XLEN-1){1'b0}}, $signed(i_rs1_data) < $signed(imm_i_ext)};
                    end
                    3'b011: o_result <= {{(XLEN-1){1'b0}}, i_rs1_data < imm_i_ext};  // SLTIU
                    3'b100: o_result <= i_rs1_data ^ imm_i_ext;  // XORI
                    3'b101: begin  // SRLI/SRAI
                        o_exception <= i_i_imm[31] || (i_i_imm[29:26] != '0);
                        o_result    <= shr64(i_rs1_data, shamt_i, alt);
                    end
                    3'b110: o_result <= i_rs1_data | imm_i_ext;  // ORI
                    3'b111: o_result <= i_rs1_data & imm_i_ext;  // ANDI
                endcase
            end
            OPC_OP_IMM_32: begin
                case (i_funct3)
                    3'b000: o_result <= sext32(i_rs1_data[31:0] + imm_i_ext[31:0]);  // ADDIW
                    3'b001: begin  // SLLIW
                        o_exception <= i_i_imm[31:25] != '0;
                        o_result    <= sext32(i_rs1_data[31:0] << i_i_imm[24:20]);
                    end
                    3'b101: begin  // SRLIW/SRAIW
                        o_exception <= i_i_imm[31] || (i_i_imm[29:25] != '0);
                        o_result    <= sext32(shr32(i_rs1_data[31:0], i_i_imm[24:20], alt));
                    end
                    default: o_exception <= 1'b1;
                endcase
            end
            OPC_OP: begin
                unique case (i_funct3)
                    3'b000: begin  // ADD/SUB
                        o_result <= alt ? i_rs1_data - i_rs2_data : i_rs1_data + i_rs2_data;
                    end
                    3'b001: o_result <= i_rs1_data << shamt_r;  // SLL
                    3'b010: begin  // SLT
                        o_result <= {{(XLEN-1){1'b0}}, $signed(i_rs1_data) < $signed(i_rs2_data)};
                    end
                    3'b011: o_result <= {{(XLEN-1){1'b0}}, i_rs1_data < i_rs2_data};  // SLTU
                    3'b100: o_result <= i_rs1_data ^ i_rs2_data;
                    3'b101: o_result <= shr64(i_rs1_data, shamt_r, alt);  // SRL/SRA
                    3'b110: o_result <= i_rs1_data | i_rs2_data;
                    3'b111: o_result <= i_rs1_data & i_rs2_data;
                endcase
            end
            OPC_OP_32: begin
                case (i_funct3)
                    3'b000: begin  // ADDW/SUBW
                        o_result <= sext32(alt ? i_rs1_data[31:0] - i_rs2_data[31:0]
                                               : i_rs1_data[31:0] + i_rs2_data[31:0]);
                    end
                    3'b001: o_result <= sext32(i_rs1_data[31:0] << shamt_r[4:0]);  // SLLW
                    3'b101: begin  // SRLW/SRAW
                        o_result <= sext32(shr32(i_rs1_data[31:0], shamt_r[4:0], alt));
                    end
                    default: o_exception <= 1'b1;
                endcase
            end
            default: begin
                // Loads, stores, branches, system and anything else
                o_exception <= 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/int_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_regfile (
    input  wire                     clk,
    input  wire                     rst,

    // Read ports
    input  wire  rv_pkg::reg_idx_t  i_rs1_addr,
    input  wire  rv_pkg::reg_idx_t  i_rs2_addr,
    output rv_pkg::xlen_t           o_rs1_data,
    output rv_pkg::xlen_t           o_rs2_data,

    // Write port
    input  wire                     i_wr_en,
    input  wire  rv_pkg::reg_idx_t  i_wr_addr,
    input  wire  rv_pkg::xlen_t     i_wr_data
);
    import rv_pkg::*;

    xlen_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // One read port, write data bypasses the array on a match
    function automatic xlen_t read_port(input reg_idx_t addr);
        if (addr == '0) begin
            return '0;
        end else if (i_wr_en && (addr == i_wr_addr)) begin
            return i_wr_data;
        end else begin
            return regs[addr];
        end
    endfunction

    always_comb begin
        o_rs1_data = read_port(i_rs1_addr);
        o_rs2_data = read_port(i_rs2_addr);
    end

endmodule

`default_nettype wire

// ==== hdl/int_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_decode (
    input  wire                     clk,
    input  wire                     rst,

    input  wire                     i_valid,
    input  wire  rv_pkg::instr_t    i_instr,
    input  wire  rv_pkg::addr_t     i_pc,

    // Register file read side
    output rv_pkg::reg_idx_t        o_rs1_addr,
    output rv_pkg::reg_idx_t        o_rs2_addr,
    input  wire  rv_pkg::xlen_t     i_rs1_data,
    input  wire  rv_pkg::xlen_t     i_rs2_data,

    // Decode stage outputs
    output logic                    o_valid,
    output rv_pkg::addr_t           o_pc,
    output rv_pkg::opcode_t         o_opcode,
    output logic [2:0]              o_funct3,
    output rv_pkg::reg_idx_t        o_rd,
    output rv_pkg::xlen_t           o_rs1_data,
    output rv_pkg::xlen_t           o_rs2_data,
    output logic [31:20]            o_i_imm,
    output logic [31:12]            o_u_imm
);

    // Source register fields go straight to the register file
    assign o_rs1_addr = i_instr[19:15];
    assign o_rs2_addr = i_instr[24:20];

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        o_pc       <= i_pc;
        o_funct3   <= i_instr[14:12];
        o_rd       <= i_instr[11:7];
        o_rs1_data <= i_rs1_data;  // Already includes write-through
        o_rs2_data <= i_rs2_data;
        o_i_imm    <= i_instr[31:20];
        o_u_imm    <= i_instr[31:12];

        // Non-32-bit encodings get an opcode that no case decodes
        if (i_instr[1:0] == 2'b11) begin
            o_opcode <= i_instr[6:2];
        end else begin
            o_opcode <= 5'b11111;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // Datapath and address widths
    localparam int XLEN = 64;
    localparam int ALEN = 64;

    typedef logic [XLEN-1:0] xlen_t;     // Register data and results
    typedef logic [ALEN-1:0] addr_t;     // Instruction address
    typedef logic [31:0]     instr_t;    // Raw instruction word
    typedef logic [4:0]      reg_idx_t;  // Register index
    typedef logic [4:0]      opcode_t;   // Instruction bits 6 to 2
    typedef logic [3:0]      trap_cause_t;

    // Major opcodes, bits 6 to 2 of the instruction
    localparam opcode_t OPC_LUI       = 5'b01101;
    localparam opcode_t OPC_AUIPC     = 5'b00101;
    localparam opcode_t OPC_OP_IMM    = 5'b00100;
    localparam opcode_t OPC_OP_IMM_32 = 5'b00110;
    localparam opcode_t OPC_OP        = 5'b01100;
    localparam opcode_t OPC_OP_32     = 5'b01110;

    // Exception cause codes
    localparam trap_cause_t EXC_ILLEGAL_INSTR = 4'd2;

endpackage

`default_nettype wire
